//--- rtl/rtp_pkg.sv
/* shared widths, RTP protocol constants, frame geometry and framer state codes
   for the RTP video line packetizer; modules import it inside their bodies */
package rtp_pkg;

  // ************************************************************
  // datapath widths
  // ************************************************************

  // one stream beat is eight bytes, byte 0 in bits 63:56
  localparam int DATA_W = 64;
  localparam int KEEP_W = DATA_W / 8;

  // line fifo geometry, a whole line must fit
  localparam int FIFO_DEPTH = 32;
  localparam int FIFO_AW    = 5;

  // ************************************************************
  // frame geometry
  // ************************************************************

  // payload beats per video line
  localparam int LINE_BEATS = 8;

  // payload header length field, bytes per line
  localparam logic [15:0] LINE_BYTES = 16'(LINE_BEATS * 8);

  // kept small so a whole frame runs quickly in simulation
  localparam int LINES_PER_FRAME = 4;

  // ************************************************************
  // RTP protocol constants
  // ************************************************************

  localparam logic [1:0]  RTP_VERSION = 2'd2;
  // dynamic payload type used for uncompressed video
  localparam logic [6:0]  RTP_PT      = 7'd96;
  localparam logic [31:0] SSRC_ID     = 32'h1A2B3C4D;

  // media clock and frame rate give the per-frame timestamp step
  localparam int          RTP_CLK_HZ   = 90000;
  localparam int          FRAME_RATE   = 30;
  localparam logic [31:0] TS_INCREMENT = 32'(RTP_CLK_HZ / FRAME_RATE);

  // full beat, and ssrc beat with only bytes 0..3 (bits 63:32) valid
  localparam logic [KEEP_W-1:0] KEEP_FULL = {KEEP_W{1'b1}};
  localparam logic [KEEP_W-1:0] KEEP_SSRC = {{(KEEP_W/2){1'b1}}, {(KEEP_W/2){1'b0}}};

  // ************************************************************
  // framer states
  // ************************************************************

  localparam logic [2:0] ST_IDLE    = 3'd0;
  localparam logic [2:0] ST_HDR0    = 3'd1;
  localparam logic [2:0] ST_HDR1    = 3'd2;
  localparam logic [2:0] ST_PDHDR   = 3'd3;
  localparam logic [2:0] ST_PAYLOAD = 3'd4;

endpackage

//--- rtl/line_fifo.sv
/* line buffer between the video source and the framer; stores beats with
   their tlast flag and reports when at least one complete line is held */
`timescale 1ns/1ns

module line_fifo (
  input  logic                      aclk,
  input  logic                      aresetn,

  // video line input stream
  input  logic                      s_tvalid,
  input  logic [rtp_pkg::DATA_W-1:0] s_tdata,
  input  logic                      s_tlast,
  output logic                      s_tready,

  // read side towards the framer
  input  logic                      fifo_pop,
  output logic                      fifo_valid,
  output logic [rtp_pkg::DATA_W-1:0] fifo_data,
  output logic                      fifo_last,
  output logic                      line_ready
);

  import rtp_pkg::*;

  // storage, one entry is {last, data}
  logic [DATA_W:0]   mem [FIFO_DEPTH];

  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  // occupancy in beats, one bit wider than the pointers
  logic [FIFO_AW:0]   count;
  // number of stored beats carrying tlast
  logic [FIFO_AW:0]   last_cnt;

  logic               push;
  logic               pop;

  // ************************************************************
  // handshake
  // ************************************************************

  // back-pressure only when every entry is taken
  assign s_tready   = (count != FIFO_DEPTH);
  assign fifo_valid = (count != '0);

  assign push = s_tvalid && s_tready;
  // a pop on an empty buffer is ignored
  assign pop  = fifo_pop && fifo_valid;

  // ************************************************************
  // storage and pointers
  // ************************************************************

  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= {s_tlast, s_tdata};
    end
  end

  // head entry read straight out of the array
  assign fifo_last = mem[rd_ptr][DATA_W];
  assign fifo_data = mem[rd_ptr][DATA_W-1:0];

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap on their own, depth is a power of two
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // ************************************************************
  // complete line tracking
  // ************************************************************

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      last_cnt <= '0;
    end else begin
      // up on a stored tlast, down on a popped one, both may happen together
      if ((push && s_tlast) && !(pop && fifo_last)) begin
        last_cnt <= last_cnt + 1'b1;
      end else if ((pop && fifo_last) && !(push && s_tlast)) begin
        last_cnt <= last_cnt - 1'b1;
      end
    end
  end

  assign line_ready = (last_cnt != '0);

endmodule

//--- rtl/rtp_header_gen.sv
/* per-packet RTP state (sequence, line, timestamp) and the three header beats
   derived from it; everything advances on the framer's packet_done pulse */
`timescale 1ns/1ns

module rtp_header_gen (
  input  logic                       aclk,
  input  logic                       aresetn,

  // one cycle pulse, last payload beat of a packet loaded
  input  logic                       packet_done,

  // RTP fixed header, first and second beat
  output logic [rtp_pkg::DATA_W-1:0] hdr_word0,
  output logic [rtp_pkg::DATA_W-1:0] hdr_word1,
  // video payload header beat
  output logic [rtp_pkg::DATA_W-1:0] pd_hdr_word
);

  import rtp_pkg::*;

  // full 32-bit sequence, low half in RTP header, high half in payload header
  logic [31:0] seq_num;
  // line number within the frame, 15 bits as in the payload header
  logic [14:0] line_num;
  // shared by all packets of a frame
  logic [31:0] timestamp;
  logic        marker;

  // ************************************************************
  // counters
  // ************************************************************

  // last line of a progressive frame carries the marker
  assign marker = (line_num == 15'(LINES_PER_FRAME - 1));

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      seq_num <= '0;
    end else if (packet_done) begin
      // free running, wraps naturally at 2^32
      seq_num <= seq_num + 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      line_num <= '0;
    end else if (packet_done) begin
      if (marker) begin
        line_num <= '0;
      end else begin
        line_num <= line_num + 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      timestamp <= '0;
    end else if (packet_done && marker) begin
      // frame finished, next frame's timestamp one frame period later
      timestamp <= timestamp + TS_INCREMENT;
    end
  end

  // ************************************************************
  // header beats
  // ************************************************************

  // beat 0: V, P, X, CC, M, PT, seq low, timestamp
  assign hdr_word0 = {
    RTP_VERSION,
    1'b0,               // padding
    1'b0,               // extension
    4'h0,               // csrc count
    marker,
    RTP_PT,
    seq_num[15:0],
    timestamp
  };

  // beat 1: ssrc in the upper four bytes, rest masked by tkeep
  assign hdr_word1 = {SSRC_ID, 32'h0000_0000};

  // beat 2: extended seq, length, F + line number, C + offset
  assign pd_hdr_word = {
    seq_num[31:16],
    LINE_BYTES,
    1'b0,               // field id, progressive video
    line_num,
    1'b0,               // continuation, one line per packet
    15'h0000            // offset, line always starts at pixel 0
  };

endmodule

//--- rtl/rtp_framer.sv
/* packet sequencer: emits the three header beats then one stored line from
   the line fifo through a single registered output stage */
`timescale 1ns/1ns

module rtp_framer (
  input  logic                       aclk,
  input  logic                       aresetn,

  // line fifo read side
  input  logic                       line_ready,
  input  logic                       fifo_valid,
  input  logic [rtp_pkg::DATA_W-1:0] fifo_data,
  input  logic                       fifo_last,
  output logic                       fifo_pop,

  // header beats and packet completion towards the header generator
  input  logic [rtp_pkg::DATA_W-1:0] hdr_word0,
  input  logic [rtp_pkg::DATA_W-1:0] hdr_word1,
  input  logic [rtp_pkg::DATA_W-1:0] pd_hdr_word,
  output logic                       packet_done,

  // packet output stream
  input  logic                       m_tready,
  output logic                       m_tvalid,
  output logic [rtp_pkg::DATA_W-1:0] m_tdata,
  output logic [rtp_pkg::KEEP_W-1:0] m_tkeep,
  output logic                       m_tlast
);

  import rtp_pkg::*;

  logic [2:0]        state;
  logic [2:0]        state_next;

  // output register is free this cycle (empty or being taken)
  logic              load_en;
  // a beat is written into the output register this cycle
  logic              load;
  logic [DATA_W-1:0] load_data;
  logic [KEEP_W-1:0] load_keep;
  logic              load_last;

  assign load_en = !m_tvalid || m_tready;

  // ************************************************************
  // beat selection and next state
  // ************************************************************

  always_comb begin
    state_next = state;
    load       = 1'b0;
    load_data  = fifo_data;
    load_keep  = KEEP_FULL;
    load_last  = 1'b0;
    case (state)
      ST_IDLE: begin
        // wait for a whole line so the payload never stalls midway
        if (line_ready) begin
          state_next = ST_HDR0;
        end
      end
      ST_HDR0: begin
        load      = load_en;
        load_data = hdr_word0;
        if (load_en) begin
          state_next = ST_HDR1;
        end
      end
      ST_HDR1: begin
        load      = load_en;
        load_data = hdr_word1;
        load_keep = KEEP_SSRC;
        if (load_en) begin
          state_next = ST_PDHDR;
        end
      end
      ST_PDHDR: begin
        load      = load_en;
        load_data = pd_hdr_word;
        if (load_en) begin
          state_next = ST_PAYLOAD;
        end
      end
      ST_PAYLOAD: begin
        // line beats pass through unchanged
        load      = load_en && fifo_valid;
        load_last = fifo_last;
        if (load && fifo_last) begin
          state_next = ST_IDLE;
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  // pop exactly the payload beats that get loaded
  assign fifo_pop    = load && (state == ST_PAYLOAD);
  // tells the header generator the packet is complete
  assign packet_done = fifo_pop && fifo_last;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // ************************************************************
  // output stage
  // ************************************************************

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      m_tvalid <= 1'b0;
    end else if (load_en) begin
      // drop valid after a transfer unless a new beat comes in behind it
      m_tvalid <= load;
    end
  end

  // payload side of the register, held while the sink stalls
  always_ff @(posedge aclk) begin
    if (load) begin
      m_tdata <= load_data;
      m_tkeep <= load_keep;
      m_tlast <= load_last;
    end
  end

endmodule

//--- rtl/rtp_engine.sv
/* RTP packetizer top: line fifo feeding the framer, header generator
   supplying the per-packet header beats */
`timescale 1ns/1ns

module rtp_engine (
  input  logic                       aclk,
  input  logic                       aresetn,

  // video line input
  input  logic                       s_tvalid,
  input  logic [rtp_pkg::DATA_W-1:0] s_tdata,
  input  logic                       s_tlast,
  output logic                       s_tready,

  // RTP packet output
  input  logic                       m_tready,
  output logic                       m_tvalid,
  output logic [rtp_pkg::DATA_W-1:0] m_tdata,
  output logic [rtp_pkg::KEEP_W-1:0] m_tkeep,
  output logic                       m_tlast
);

  import rtp_pkg::*;

  // fifo read side
  logic              fifo_valid;
  logic [DATA_W-1:0] fifo_data;
  logic              fifo_last;
  logic              fifo_pop;
  logic              line_ready;

  // header path
  logic              packet_done;
  logic [DATA_W-1:0] hdr_word0;
  logic [DATA_W-1:0] hdr_word1;
  logic [DATA_W-1:0] pd_hdr_word;

  line_fifo i_line_fifo (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .s_tvalid   (s_tvalid),
    .s_tdata    (s_tdata),
    .s_tlast    (s_tlast),
    .s_tready   (s_tready),
    .fifo_pop   (fifo_pop),
    .fifo_valid (fifo_valid),
    .fifo_data  (fifo_data),
    .fifo_last  (fifo_last),
    .line_ready (line_ready)
  );

  rtp_header_gen i_header_gen (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .packet_done (packet_done),
    .hdr_word0   (hdr_word0),
    .hdr_word1   (hdr_word1),
    .pd_hdr_word (pd_hdr_word)
  );

  rtp_framer i_framer (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .line_ready  (line_ready),
    .fifo_valid  (fifo_valid),
    .fifo_data   (fifo_data),
    .fifo_last   (fifo_last),
    .fifo_pop    (fifo_pop),
    .hdr_word0   (hdr_word0),
    .hdr_word1   (hdr_word1),
    .pd_hdr_word (pd_hdr_word),
    .packet_done (packet_done),
    .m_tready    (m_tready),
    .m_tvalid    (m_tvalid),
    .m_tdata     (m_tdata),
    .m_tkeep     (m_tkeep),
    .m_tlast     (m_tlast)
  );

endmodule

//--- sim/tb_rtp_tasks.svh
/* testbench helpers for the RTP packetizer: value check, LCG source and the
   reference model of the per-packet header; included inside the testbench */
`ifndef TB_RTP_TASKS_SVH
`define TB_RTP_TASKS_SVH

// ************************************************************
// checking and random source
// ************************************************************

task automatic check_value(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
  end
endtask

// 32-bit LCG, full period constants
function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// true with a chance of sixteenths/16, from the top bits of the LCG
function automatic bit chance16(input int sixteenths);
  logic [31:0] r;
  r = lcg_next();
  return (int'(r[31:28]) < sixteenths);
endfunction

// ************************************************************
// header reference model
// ************************************************************

// V=2, P=0, X=0, CC=0, marker on the frame's last line, PT, seq low, ts
function automatic logic [63:0] expect_hdr0(input logic [31:0] seq,
                                            input logic [14:0] line,
                                            input logic [31:0] ts);
  logic marker;
  marker = (line == 15'(LINES_PER_FRAME - 1));
  return {2'd2, 2'b00, 4'h0, marker, RTP_PT, seq[15:0], ts};
endfunction

// extended seq, line length in bytes, F=0 + line, C=0 + offset 0
function automatic logic [63:0] expect_pd_hdr(input logic [31:0] seq,
                                              input logic [14:0] line);
  return {seq[31:16], 16'(LINE_BEATS * 8), 1'b0, line, 16'h0000};
endfunction

task automatic advance_model();
  model_seq = model_seq + 1;
  if (model_line == 15'(LINES_PER_FRAME - 1)) begin
    model_line = '0;
    // new frame, one frame period later
    model_ts   = model_ts + TS_INCREMENT;
  end else begin
    model_line = model_line + 1'b1;
  end
endtask

`endif

//--- sim/tb_rtp_engine.sv
/* testbench for the RTP packetizer top that runs a table of line streams with
   random gaps and sink stalls and checks every output beat against a model */
`timescale 1ns/1ns

module tb_rtp_engine;

  import rtp_pkg::*;

  localparam int          NUM_ROWS = 4;
  localparam logic [31:0] LCG_SEED = 32'd5701;

  logic              aclk;
  logic              aresetn;
  logic              s_tvalid;
  logic [DATA_W-1:0] s_tdata;
  logic              s_tlast;
  logic              s_tready;
  logic              m_tready;
  logic              m_tvalid;
  logic [DATA_W-1:0] m_tdata;
  logic [KEEP_W-1:0] m_tkeep;
  logic              m_tlast;

  // stimulus table with chances in sixteenths
  string row_name      [NUM_ROWS];
  int    row_lines     [NUM_ROWS];
  int    row_gap       [NUM_ROWS];
  // m_tready held low for this many cycles at row start
  int    row_stall     [NUM_ROWS];
  int    row_rdy_low   [NUM_ROWS];
  bit    row_need_full [NUM_ROWS];

  logic [DATA_W-1:0] exp_q [$];
  logic [31:0]       lcg_state;
  int                errors;
  int                checks;
  int                cycle_count = 0;
  int                timeout_limit = 1000;
  // expected header state
  logic [31:0]       model_seq;
  logic [14:0]       model_line;
  logic [31:0]       model_ts;
  int                out_beat;
  int                packets_seen;
  bit                saw_full;

  `include "tb_rtp_tasks.svh"

  rtp_engine dut0 (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .s_tvalid (s_tvalid),
    .s_tdata  (s_tdata),
    .s_tlast  (s_tlast),
    .s_tready (s_tready),
    .m_tready (m_tready),
    .m_tvalid (m_tvalid),
    .m_tdata  (m_tdata),
    .m_tkeep  (m_tkeep),
    .m_tlast  (m_tlast)
  );

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  // watchdog on the whole run
  always @(posedge aclk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("timeout after %0d cycles: output packets did not arrive", cycle_count);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic load_table();
    row_name      = '{"single_pkt", "frame_count", "backpressure", "fifo_fill"};
    row_lines     = '{1, LINES_PER_FRAME + 2, 10, 8};
    row_gap       = '{0, 0, 0, 4};
    row_stall     = '{0, 0, 0, 80};
    row_rdy_low   = '{0, 0, 6, 3};
    row_need_full = '{0, 0, 0, 1};
  endtask

  // ************************************************************
  // output monitor for a beat that transfers on the next edge
  // ************************************************************

  task automatic check_output_beat();
    logic [DATA_W-1:0] exp_data;
    exp_data = m_tdata;
    case (out_beat)
      0: exp_data = expect_hdr0(model_seq, model_line, model_ts);
      1: exp_data = {SSRC_ID, 32'h0000_0000};
      2: exp_data = expect_pd_hdr(model_seq, model_line);
      default: begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("payload beat at %0t has no input beat left to match", $time);
        end else begin
          exp_data = exp_q.pop_front();
        end
      end
    endcase
    check_value("m_tdata", m_tdata, exp_data);
    check_value("m_tkeep", m_tkeep, (out_beat == 1) ? KEEP_SSRC : KEEP_FULL);
    check_value("m_tlast", m_tlast, out_beat == LINE_BEATS + 2);
    if (out_beat == LINE_BEATS + 2) begin
      advance_model();
      out_beat = 0;
      packets_seen++;
    end else begin
      out_beat++;
    end
  endtask

  // ************************************************************
  // one table row with source, sink and monitor in lock step
  // ************************************************************

  task automatic run_row(input int row);
    int                lines_sent;
    int                beat_num;
    int                row_cycle;
    bit                in_xfer;
    bit                out_xfer;
    logic [DATA_W-1:0] word;
    lines_sent   = 0;
    beat_num     = 0;
    row_cycle    = 0;
    packets_seen = 0;
    saw_full     = 1'b0;
    while (packets_seen < row_lines[row]) begin
      // values sampled between edges transfer on the next rise
      @(negedge aclk);
      in_xfer  = s_tvalid && s_tready;
      out_xfer = m_tvalid && m_tready;
      if (!s_tready) begin
        saw_full = 1'b1;
      end
      if (out_xfer) begin
        check_output_beat();
      end
      @(posedge aclk);
      row_cycle++;
      // a new input beat only once the offered one has gone
      if (in_xfer || !s_tvalid) begin
        if (lines_sent < row_lines[row] && !chance16(row_gap[row])) begin
          word[63:32] = lcg_next();
          word[31:0]  = lcg_next();
          exp_q.push_back(word);
          s_tvalid <= 1'b1;
          s_tdata  <= word;
          s_tlast  <= (beat_num == LINE_BEATS - 1);
          if (beat_num == LINE_BEATS - 1) begin
            beat_num = 0;
            lines_sent++;
          end else begin
            beat_num++;
          end
        end else begin
          s_tvalid <= 1'b0;
        end
      end
      if (row_cycle < row_stall[row]) begin
        m_tready <= 1'b0;
      end else begin
        m_tready <= !chance16(row_rdy_low[row]);
      end
    end
  endtask

  initial begin
    int tests_failed;
    int err_start;
    s_tvalid   = 1'b0;
    s_tdata    = '0;
    s_tlast    = 1'b0;
    m_tready   = 1'b0;
    aresetn    = 1'b0;
    lcg_state  = LCG_SEED;
    errors     = 0;
    checks     = 0;
    model_seq  = '0;
    model_line = '0;
    model_ts   = '0;
    out_beat   = 0;
    tests_failed = 0;
    load_table();
    // worst case per row plus a fixed margin
    timeout_limit = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      timeout_limit += row_lines[r] * (LINE_BEATS + 4) * 16 + 200 + row_stall[r];
    end
    repeat (8) @(posedge aclk);
    aresetn <= 1'b1;
    @(negedge aclk);
    check_value("m_tvalid", m_tvalid, 1'b0);
    check_value("s_tready", s_tready, 1'b1);
    for (int r = 0; r < NUM_ROWS; r++) begin
      err_start = errors;
      run_row(r);
      if (exp_q.size() != 0) begin
        errors++;
        $display("%0d input beats never came out of the packetizer", exp_q.size());
      end
      if (row_need_full[r] && !saw_full) begin
        errors++;
        $display("s_tready never went low while the sink was stalled");
      end
      if (errors != err_start) begin
        tests_failed++;
      end
      $display("test %s packets %0d errors %0d", row_name[r], packets_seen,
               errors - err_start);
    end
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             NUM_ROWS, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+sim
rtl/rtp_pkg.sv
rtl/line_fifo.sv
rtl/rtp_header_gen.sv
rtl/rtp_framer.sv
rtl/rtp_engine.sv
sim/tb_rtp_engine.sv

//--- run_sim.sh
#!/bin/sh
# build and run the RTP packetizer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_rtp_engine \
  -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_rtp_engine > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the testbench result decides the exit status
if grep -q "STATUS: FAIL" "$LOG"; then
  exit 1
fi
exit 0
